//--- sources.f
+incdir+include
rtl/dz_pkg.sv
rtl/dz_countdown_sequencer.sv
rtl/dz_row_scanner.sv
rtl/dz_glyph_renderer.sv
rtl/dz_countdown_top.sv
bench/dz_display_model.sv
bench/dz_countdown_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = dz_countdown_tb
FILELIST  = sources.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Finished with no errors$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/dz_countdown_tb.sv
`timescale 1ns/1ns
`include "dz_macros.svh"

module dz_countdown_tb
    import dz_pkg::*;
();

    localparam int RUNS        = 12;
    localparam int HOLD_MAX    = 96;
    localparam int RUN_LEN     = 6 * `DZ_TICK_DIV;
    localparam int CYCLE_LIMIT = RUNS * RUN_LEN + RUNS * HOLD_MAX + RUN_LEN + 100;

    logic         clk;
    logic         rst;
    logic         start;
    logic         hold;
    matrix_line_t line;
    digit_t       digit;
    logic         done;
    matrix_line_t exp_line;
    digit_t       exp_digit;
    logic         exp_done;

    int unsigned  cycle_count;
    int unsigned  done_count;
    logic         started;
    logic [7:0]   prev_row;
    logic [7:0]   rows_seen;
    int unsigned  run_len;
    logic         span_ok;

    dz_countdown_top uut (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .hold  (hold),
        .line  (line),
        .digit (digit),
        .done  (done)
    );

    dz_display_model ref_model (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .hold      (hold),
        .exp_digit (exp_digit),
        .exp_done  (exp_done),
        .exp_line  (exp_line)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic stop_run();
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                   input logic [31:0] act_v);
        $display("[ERROR] %s: expected %0h, actual %0h", name, exp_v, act_v);
        stop_run();
    endtask

    task automatic report_problem(input string what);
        $display("%s", what);
        stop_run();
    endtask

    // one start pulse, then gap cycles with an optional hold stretch inside
    task automatic run_countdown(input int unsigned gap, input int unsigned hold_at,
                                 input int unsigned hold_len, input bit start_in_hold);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        for (int unsigned c = 0; c < gap; c++)
        begin
            if (c == hold_at && hold_len != 0)
            begin
                hold <= 1'b1;
                for (int unsigned h = 0; h < hold_len; h++)
                begin
                    start <= start_in_hold && (h == hold_len / 2);
                    @(posedge clk);
                end
                start <= 1'b0;
                hold  <= 1'b0;
            end
            @(posedge clk);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    initial
    begin
        int unsigned gap;
        int unsigned hold_at;
        int unsigned hold_len;
        bit          in_hold;
        rst   = 1'b1;
        start = 1'b0;
        hold  = 1'b0;
        void'($urandom(32'h2bcc_38bf));
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        repeat (5) @(posedge clk);   // the line must stay dark before the first start
        for (int i = 0; i < RUNS; i++)
        begin
            if (i == 1 || ($urandom % 3) == 0)
                gap = 8 + $urandom % (4 * `DZ_TICK_DIV);        // cut short by the next start
            else
                gap = 5 * `DZ_TICK_DIV + 4 + $urandom % (`DZ_TICK_DIV / 2);
            in_hold  = (i == 2) || (($urandom % 4) == 0);
            hold_at  = $urandom % gap;
            hold_len = in_hold ? 2 + $urandom % (HOLD_MAX - 2) : $urandom % HOLD_MAX;
            run_countdown(gap, hold_at, hold_len, in_hold);
        end
        while (digit != 3'd0)
            @(negedge clk);
        repeat (4) @(posedge clk);
        assert (done_count > 0) else report_problem("no countdown reached 0");
        assert (rows_seen == 8'hff) else report_problem("the scan missed some rows");
        $display("Finished with no errors");
        $finish;
    end

    initial
    begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT)
        begin
            @(posedge clk);
            cycle_count++;
        end
        report_problem("run did not finish within the cycle limit");
    end

    //////////////////////////////////////////////////////////////////////
    // checks against the reference model
    //////////////////////////////////////////////////////////////////////

    initial
    begin
        done_count = 0;
        started    = 1'b0;
        prev_row   = 8'd0;
        rows_seen  = 8'd0;
        run_len    = 1;
        span_ok    = 1'b0;
    end

    always @(negedge clk)
    begin
        assert (digit == exp_digit) else report_mismatch("digit", 32'(exp_digit), 32'(digit));
        assert (done == exp_done) else report_mismatch("done", 32'(exp_done), 32'(done));
        assert (line == exp_line) else report_mismatch("line", 32'(exp_line), 32'(line));
        if (!started)
            assert (line == '0) else report_mismatch("idle line", 32'd0, 32'(line));
        if (!rst)
        begin
            if (start)
                started = 1'b1;
            if (done)
                done_count++;

            // the lit row steps left by one, wrapping 7 to 0, once per scan period
            if (line.row != 8'd0 && line.row == prev_row)
                run_len++;
            else if (line.row != 8'd0 && prev_row != 8'd0)
            begin
                assert (line.row == {prev_row[6:0], prev_row[7]})
                    else report_mismatch("scan order", 32'({prev_row[6:0], prev_row[7]}),
                                         32'(line.row));
                if (span_ok)
                    assert (run_len == `DZ_SCAN_DIV)
                        else report_mismatch("scan period", 32'(`DZ_SCAN_DIV), 32'(run_len));
                span_ok = 1'b1;
                run_len = 1;
            end
            else
            begin
                span_ok = 1'b0;
                run_len = 1;
            end
            rows_seen = rows_seen | line.row;
            prev_row  = line.row;
        end
    end

endmodule

//--- bench/dz_display_model.sv
`timescale 1ns/1ns
`include "dz_macros.svh"

module dz_display_model
    import dz_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         start,
    input  logic         hold,
    output digit_t       exp_digit,
    output logic         exp_done,
    output matrix_line_t exp_line
);

    // glyph bitmaps with row 0 in the top byte
    localparam logic [63:0] SHAPE_5 = 64'h00_7E_60_7C_06_06_66_3C;
    localparam logic [63:0] SHAPE_4 = 64'h00_0C_1C_2C_4C_7E_0C_0C;
    localparam logic [63:0] SHAPE_3 = 64'h00_3C_66_06_1C_06_66_3C;
    localparam logic [63:0] SHAPE_2 = 64'h00_3C_66_06_0C_30_60_7E;
    localparam logic [63:0] SHAPE_1 = 64'h00_18_18_38_18_18_18_7E;

    int unsigned  ticks_left;   // counting cycles still needed for the next step
    int unsigned  cycles;       // clock edges since reset, drives the scan position
    row_idx_t     row_now;
    matrix_line_t line_now;
    matrix_line_t line_dly;

    function automatic logic [7:0] shape_row(input digit_t d, input row_idx_t r);
        logic [63:0] shape;
        case (d)
            3'd5: shape = SHAPE_5;
            3'd4: shape = SHAPE_4;
            3'd3: shape = SHAPE_3;
            3'd2: shape = SHAPE_2;
            3'd1: shape = SHAPE_1;
            default: shape = 64'd0;
        endcase
        return shape[8 * (7 - int'(r)) +: 8];
    endfunction

    function automatic matrix_line_t expected_line(input digit_t d, input row_idx_t r);
        matrix_line_t l;
        logic [7:0]   bits;
        bits = shape_row(d, r);
        l = '0;
        if (d != 3'd0)
            l.row = 8'd1 << r;
        case (d)
            3'd5, 3'd4: l.colr = bits;    // red
            3'd3, 3'd2:
            begin
                l.colr = bits;            // yellow lights both colors
                l.colg = bits;
            end
            3'd1: l.colg = bits;          // green
            default: l = '0;
        endcase
        return l;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // countdown
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            exp_digit  <= '0;
            exp_done   <= 1'b0;
            ticks_left <= `DZ_TICK_DIV;
        end
        else if (start)
        begin
            exp_digit  <= digit_t'(`DZ_START_DIGIT);
            exp_done   <= 1'b0;
            ticks_left <= `DZ_TICK_DIV;
        end
        else if (exp_digit != 3'd0 && !hold)
        begin
            if (ticks_left == 1)
            begin
                exp_digit  <= exp_digit - 3'd1;
                exp_done   <= (exp_digit == 3'd1);
                ticks_left <= `DZ_TICK_DIV;
            end
            else
            begin
                exp_done   <= 1'b0;
                ticks_left <= ticks_left - 1;
            end
        end
        else
            exp_done <= 1'b0;
    end

    //////////////////////////////////////////////////////////////////////
    // scan position and the two-cycle line delay
    //////////////////////////////////////////////////////////////////////

    assign row_now  = row_idx_t'((cycles / `DZ_SCAN_DIV) % 8);
    assign line_now = expected_line(exp_digit, row_now);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            cycles   <= 0;
            line_dly <= '0;
            exp_line <= '0;
        end
        else
        begin
            cycles   <= cycles + 1;
            line_dly <= line_now;
            exp_line <= line_dly;
        end
    end

endmodule

//--- rtl/dz_countdown_top.sv
`timescale 1ns/1ns

module dz_countdown_top
    import dz_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         start,
    input  logic         hold,
    output matrix_line_t line,
    output digit_t       digit,
    output logic         done
);

    row_idx_t  row_idx;
    scan_pos_t pos;

    dz_countdown_sequencer u_sequencer (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .hold  (hold),
        .digit (digit),
        .done  (done)
    );

    dz_row_scanner u_scanner (
        .clk     (clk),
        .rst     (rst),
        .row_idx (row_idx)
    );

    // digit and row travel together into the renderer pipeline
    assign pos.digit   = digit;
    assign pos.row_idx = row_idx;

    dz_glyph_renderer u_renderer (
        .clk  (clk),
        .rst  (rst),
        .pos  (pos),
        .line (line)
    );

endmodule

//--- rtl/dz_glyph_renderer.sv
`timescale 1ns/1ns

module dz_glyph_renderer
    import dz_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  scan_pos_t    pos,
    output matrix_line_t line
);

    //////////////////////////////////////////////////////////////////////
    // glyph table, rows 1 to 7 hold the shape and row 0 stays blank
    //////////////////////////////////////////////////////////////////////

    function automatic logic [7:0] glyph_row(input digit_t d, input row_idx_t r);
        logic [7:0] bits;
        bits = 8'b0000_0000;
        case (d)
            3'd5:
            begin
                case (r)
                    3'd1: bits = 8'b0111_1110;
                    3'd2: bits = 8'b0110_0000;
                    3'd3: bits = 8'b0111_1100;
                    3'd4: bits = 8'b0000_0110;
                    3'd5: bits = 8'b0000_0110;
                    3'd6: bits = 8'b0110_0110;
                    3'd7: bits = 8'b0011_1100;
                    default: bits = 8'b0000_0000;
                endcase
            end
            3'd4:
            begin
                case (r)
                    3'd1: bits = 8'b0000_1100;
                    3'd2: bits = 8'b0001_1100;
                    3'd3: bits = 8'b0010_1100;
                    3'd4: bits = 8'b0100_1100;
                    3'd5: bits = 8'b0111_1110;
                    3'd6: bits = 8'b0000_1100;
                    3'd7: bits = 8'b0000_1100;
                    default: bits = 8'b0000_0000;
                endcase
            end
            3'd3:
            begin
                case (r)
                    3'd1: bits = 8'b0011_1100;
                    3'd2: bits = 8'b0110_0110;
                    3'd3: bits = 8'b0000_0110;
                    3'd4: bits = 8'b0001_1100;
                    3'd5: bits = 8'b0000_0110;
                    3'd6: bits = 8'b0110_0110;
                    3'd7: bits = 8'b0011_1100;
                    default: bits = 8'b0000_0000;
                endcase
            end
            3'd2:
            begin
                case (r)
                    3'd1: bits = 8'b0011_1100;
                    3'd2: bits = 8'b0110_0110;
                    3'd3: bits = 8'b0000_0110;
                    3'd4: bits = 8'b0000_1100;
                    3'd5: bits = 8'b0011_0000;
                    3'd6: bits = 8'b0110_0000;
                    3'd7: bits = 8'b0111_1110;
                    default: bits = 8'b0000_0000;
                endcase
            end
            3'd1:
            begin
                case (r)
                    3'd3: bits = 8'b0011_1000;        // the slanted top of the 1
                    3'd7: bits = 8'b0111_1110;
                    3'd0: bits = 8'b0000_0000;
                    default: bits = 8'b0001_1000;
                endcase
            end
            default: bits = 8'b0000_0000;             // 0 shows nothing
        endcase
        return bits;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // stage 1 captures the scan position
    //////////////////////////////////////////////////////////////////////

    scan_pos_t    pos_q;
    logic [7:0]   pattern;
    logic [7:0]   row_sel;
    logic         red_on;
    logic         green_on;
    matrix_line_t line_d;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            pos_q <= '0;
        else
            pos_q <= pos;
    end

    // red for 5 and 4, both colors for 3 and 2 so they show yellow, green for 1
    assign red_on   = pos_q.digit inside {[3'd2:3'd5]};
    assign green_on = pos_q.digit inside {[3'd1:3'd3]};

    assign pattern = glyph_row(pos_q.digit, pos_q.row_idx);
    assign row_sel = (pos_q.digit != 3'd0) ? (8'd1 << pos_q.row_idx) : 8'd0;

    always_comb
    begin
        line_d.row  = row_sel;
        line_d.colr = red_on ? pattern : 8'd0;
        line_d.colg = green_on ? pattern : 8'd0;
    end

    //////////////////////////////////////////////////////////////////////
    // stage 2 holds the line for the drivers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            line <= '0;
        else
            line <= line_d;
    end

    // never more than one row driven at a time
    assert property (@(posedge clk) disable iff (rst) $onehot0(line.row))
        else $error("more than one row selected");

    // columns must stay dark while no row is selected
    assert property (@(posedge clk) disable iff (rst)
        (line.row == 8'd0) |-> ((line.colr == 8'd0) && (line.colg == 8'd0)))
        else $error("columns lit with no row selected");

endmodule

//--- rtl/dz_row_scanner.sv
`timescale 1ns/1ns
`include "dz_macros.svh"

module dz_row_scanner
    import dz_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    output row_idx_t row_idx
);

    localparam int DIV_W = (`DZ_SCAN_DIV > 1) ? $clog2(`DZ_SCAN_DIV) : 1;
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`DZ_SCAN_DIV - 1);

    logic [DIV_W-1:0] div_cnt;
    logic             step;

    assign step = (div_cnt == DIV_LAST);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            div_cnt <= '0;
        else if (step)
            div_cnt <= '0;
        else
            div_cnt <= div_cnt + 1'b1;
    end

    // row 7 rolls over to row 0 by the natural 3-bit wrap
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            row_idx <= '0;
        else if (step)
            row_idx <= row_idx + 3'd1;
    end

    // each row stays lit for the full scan period
    assert property (@(posedge clk) disable iff (rst) !step |=> $stable(row_idx))
        else $error("row index moved between divider wraps");

endmodule

//--- rtl/dz_countdown_sequencer.sv
`timescale 1ns/1ns
`include "dz_macros.svh"

module dz_countdown_sequencer
    import dz_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   start,
    input  logic   hold,
    output digit_t digit,
    output logic   done
);

    localparam int PRESC_W = (`DZ_TICK_DIV > 1) ? $clog2(`DZ_TICK_DIV) : 1;
    localparam logic [PRESC_W-1:0] PRESC_LAST = PRESC_W'(`DZ_TICK_DIV - 1);

    logic [PRESC_W-1:0] presc;
    logic               counting;
    logic               tick;

    assign counting = (digit != 3'd0) && !hold;       // hold freezes the prescaler only
    assign tick     = counting && (presc == PRESC_LAST);

    //////////////////////////////////////////////////////////////////////
    // tick prescaler
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            presc <= '0;
        else if (start || tick)
            presc <= '0;                              // a restart always gets a full period
        else if (counting)
            presc <= presc + 1'b1;
    end

    //////////////////////////////////////////////////////////////////////
    // digit register and done strobe
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            digit <= '0;
            done  <= 1'b0;
        end
        else if (start)
        begin
            digit <= digit_t'(`DZ_START_DIGIT);       // start beats a tick in the same cycle
            done  <= 1'b0;
        end
        else
        begin
            if (tick)
                digit <= digit - 3'd1;
            done <= tick && (digit == 3'd1);
        end
    end

    // the counter can only be loaded with the start digit and count down from it
    assert property (@(posedge clk) disable iff (rst) digit <= `DZ_START_DIGIT)
        else $error("digit above start value");

    // the 1 to 0 step happens once per countdown
    assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else $error("done held for more than one cycle");

endmodule

//--- rtl/dz_pkg.sv
package dz_pkg;

    // countdown value, only 0 to 5 are used
    typedef logic [2:0] digit_t;

    // matrix row number, row 0 is the top row
    typedef logic [2:0] row_idx_t;

    // what the renderer needs to build one scanned row
    typedef struct packed {
        digit_t   digit;
        row_idx_t row_idx;
    } scan_pos_t;

    // one scanned row as it goes out to the LED drivers
    typedef struct packed {
        logic [7:0] row;   // one-hot row select, bit n drives row n
        logic [7:0] colr;  // red columns, bit 7 is the leftmost column
        logic [7:0] colg;  // green columns
    } matrix_line_t;

endpackage

//--- include/dz_macros.svh
`ifndef DZ_MACROS_SVH
`define DZ_MACROS_SVH

// clock cycles per countdown step, kept small so a full run stays short
`define DZ_TICK_DIV 64

// clock cycles per row step of the matrix scan
`define DZ_SCAN_DIV 4

// digit loaded by a start pulse
`define DZ_START_DIGIT 5

`endif
